// File: hw/host_pkg.sv
package host_pkg;

    //////////////////////////////////////////////////
    // host bridge bus
    //////////////////////////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // settings registers on the bridge
    localparam bridge_addr_t ADDR_RESET    = 32'h0000_0050;
    localparam bridge_addr_t ADDR_FF_SOUND = 32'h0000_020C;
    localparam bridge_addr_t ADDR_TINT     = 32'h0000_0210;
    localparam bridge_addr_t ADDR_BW       = 32'h0000_0214;

    //////////////////////////////////////////////////
    // data slots
    //////////////////////////////////////////////////

    localparam int SLOT_ID_W = 16;

    typedef enum logic [SLOT_ID_W-1:0] {
        slot_cart     = 16'd1,
        slot_palette  = 16'd3,
        slot_cgb_boot = 16'd4,
        slot_dmg_boot = 16'd5,
        slot_sgb_boot = 16'd6
    } slot_id_e;

    // tint select, zero means plain gray shades
    typedef logic [1:0] tint_t;

    // fast-forward button in the controller key word (trig_r1)
    localparam int KEY_FAST_FORWARD = 9;

endpackage

// File: hw/video_pkg.sv
package video_pkg;

    typedef logic [23:0] rgb_t;

    // 2-bit LCD shade, 0 is the lightest
    typedef logic [1:0] shade_t;

    // entry[3] sits in the top bits and serves shade 0
    // low 32 bits are unused
    typedef struct packed {
        rgb_t [3:0]  entry;
        logic [31:0] unused;
    } palette_t;

    localparam palette_t PALETTE_DEFAULT = 128'h828214517356305A5F1A3B4900000000;

    // fixed colours when no tint is selected, indexed by shade
    localparam rgb_t GRAY_LEVELS [0:3] = '{
        24'hFFFFFF,
        24'hAAAAAA,
        24'h555555,
        24'h000000
    };

    typedef logic signed [15:0] audio_t;

endpackage

// File: hw/shell_ifs.sv
`timescale 1ns/10ps

//////////////////////////////////////////////////
// settings from the host bridge
//////////////////////////////////////////////////

interface core_settings_if import host_pkg::*;;

    tint_t tint;
    logic  ff_snd_en;
    logic  bw_en;
    logic  reset_hold;

    modport regs (
        output tint,
        output ff_snd_en,
        output bw_en,
        output reset_hold
    );

    modport users (
        input tint,
        input ff_snd_en,
        input bw_en,
        input reset_hold
    );

endinterface

//////////////////////////////////////////////////
// pixel stream, one pixel per clock
//////////////////////////////////////////////////

interface pixel_if import video_pkg::*;;

    rgb_t rgb;
    logic hsync;
    logic vsync;
    logic hblank;
    logic vblank;

    modport source (output rgb, output hsync, output vsync, output hblank, output vblank);
    modport sink (input rgb, input hsync, input vsync, input hblank, input vblank);

endinterface

// File: hw/host_regs.sv
`timescale 1ns/10ps

module host_regs import host_pkg::*; #(
    parameter int RESET_HOLD_CYCLES = 1048576
) (
    input  logic             clk_sys,
    input  logic             rst,
    input  bridge_addr_t     bridge_addr,
    input  logic             bridge_rd,
    input  logic             bridge_wr,
    input  bridge_data_t     bridge_wr_data,
    output bridge_data_t     bridge_rd_data,
    core_settings_if.regs    settings
);

    localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);

    logic [HOLD_W-1:0] hold_cnt;
    tint_t             tint_q;
    logic              ff_snd_en_q;
    logic              bw_en_q;

    assign settings.tint       = tint_q;
    assign settings.ff_snd_en  = ff_snd_en_q;
    assign settings.bw_en      = bw_en_q;
    assign settings.reset_hold = (hold_cnt != '0);

    // write decode and reset-hold countdown
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hold_cnt    <= '0;
            tint_q      <= '0;
            ff_snd_en_q <= 1'b0;
            bw_en_q     <= 1'b0;
        end else begin
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            if (bridge_wr) begin
                case (bridge_addr)
                    ADDR_RESET:    hold_cnt    <= HOLD_W'(RESET_HOLD_CYCLES);
                    ADDR_FF_SOUND: ff_snd_en_q <= bridge_wr_data[0];
                    ADDR_TINT:     tint_q      <= bridge_wr_data[1:0];
                    ADDR_BW:       bw_en_q     <= bridge_wr_data[0];
                    default:       ;
                endcase
            end
        end
    end

    // readback, held until the next read strobe
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            case (bridge_addr)
                ADDR_RESET:    bridge_rd_data <= bridge_data_t'(settings.reset_hold);
                ADDR_FF_SOUND: bridge_rd_data <= bridge_data_t'(ff_snd_en_q);
                ADDR_TINT:     bridge_rd_data <= bridge_data_t'(tint_q);
                ADDR_BW:       bridge_rd_data <= bridge_data_t'(bw_en_q);
                default:       bridge_rd_data <= '0;
            endcase
        end
    end

endmodule

// File: hw/download_tracker.sv
`timescale 1ns/10ps

module download_tracker import host_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 dataslot_requestwrite,
    input  logic [SLOT_ID_W-1:0] dataslot_requestwrite_id,
    input  logic                 dataslot_allcomplete,
    input  logic                 ioctl_wr,
    core_settings_if.users       settings,
    output logic                 downloading,
    output logic                 palette_wr,
    output logic                 core_reset
);

    slot_id_e slot_q;
    logic     core_dl;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            downloading <= 1'b0;
        end else if (dataslot_requestwrite) begin
            downloading <= 1'b1;
        end else if (dataslot_allcomplete) begin
            downloading <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (dataslot_requestwrite) begin
            slot_q <= slot_id_e'(dataslot_requestwrite_id);
        end
    end

    // cart and boot rom loads keep the core in reset
    assign core_dl    = downloading &&
                        (slot_q inside {slot_cart, slot_cgb_boot, slot_dmg_boot, slot_sgb_boot});
    assign palette_wr = downloading && (slot_q == slot_palette) && ioctl_wr;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= settings.reset_hold | core_dl;
        end
    end

endmodule

// File: hw/palette_mapper.sv
`timescale 1ns/10ps

module palette_mapper import video_pkg::*; (
    input  logic           clk_sys,
    input  logic           rst,
    input  logic           palette_wr,
    input  logic [15:0]    ioctl_dout,
    input  shade_t         lcd_shade,
    input  logic           lcd_hsync,
    input  logic           lcd_vsync,
    input  logic           lcd_hblank,
    input  logic           lcd_vblank,
    core_settings_if.users settings,
    pixel_if.source        pix
);

    palette_t palette_q;
    shade_t   pal_idx;
    rgb_t     color;

    // words enter at the bottom, low byte first
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            palette_q <= PALETTE_DEFAULT;
        end else if (palette_wr) begin
            palette_q <= {palette_q[111:0], ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

    // shade 0 maps to the topmost entry
    assign pal_idx = ~lcd_shade;

    always_comb begin
        if (settings.tint != '0) begin
            color = palette_q.entry[pal_idx];
        end else begin
            color = GRAY_LEVELS[lcd_shade];
        end
    end

    always_ff @(posedge clk_sys) begin
        pix.rgb <= color;
    end

    // sync and blank stay aligned with the colour
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pix.hsync  <= 1'b0;
            pix.vsync  <= 1'b0;
            pix.hblank <= 1'b1;
            pix.vblank <= 1'b1;
        end else begin
            pix.hsync  <= lcd_hsync;
            pix.vsync  <= lcd_vsync;
            pix.hblank <= lcd_hblank;
            pix.vblank <= lcd_vblank;
        end
    end

endmodule

// File: hw/video_conditioner.sv
`timescale 1ns/10ps

module video_conditioner import video_pkg::*; #(
    parameter int HS_DELAY = 7
) (
    input  logic           clk_sys,
    input  logic           rst,
    pixel_if.sink          pix,
    core_settings_if.users settings,
    output rgb_t           video_rgb,
    output logic           video_de,
    output logic           video_hs,
    output logic           video_vs
);

    localparam int HS_CNT_W = $clog2(HS_DELAY + 1);

    logic [HS_CNT_W-1:0] hs_cnt;
    logic                hs_prev;
    logic                vs_prev;
    rgb_t                rgb_q;
    logic [7:0]          r;
    logic [7:0]          g;
    logic [7:0]          b;
    logic [7:0]          lum;

    //////////////////////////////////////////////////
    // timing
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            hs_cnt   <= '0;
        end else begin
            video_de <= ~(pix.hblank | pix.vblank);
            video_vs <= pix.vsync & ~vs_prev;
            // hsync pushed later so it never lands on the vsync pulse
            video_hs <= (hs_cnt == HS_CNT_W'(1));
            if (pix.hsync & ~hs_prev) begin
                hs_cnt <= HS_CNT_W'(HS_DELAY);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
            hs_prev  <= pix.hsync;
            vs_prev  <= pix.vsync;
        end
    end

    always_ff @(posedge clk_sys) begin
        rgb_q <= pix.rgb;
    end

    //////////////////////////////////////////////////
    // colour out
    //////////////////////////////////////////////////

    assign {r, g, b} = rgb_q;

    // approx 0.28 r + 0.56 g + 0.09 b
    assign lum = (r >> 2) + (r >> 5) + (g >> 1) + (g >> 4) + (b >> 4) + (b >> 5);

    always_comb begin
        if (!video_de) begin
            video_rgb = '0;
        end else if (settings.bw_en) begin
            video_rgb = {lum, lum, lum};
        end else begin
            video_rgb = rgb_q;
        end
    end

endmodule

// File: hw/turbo_control.sv
`timescale 1ns/10ps

module turbo_control import host_pkg::*, video_pkg::*; #(
    parameter int TAP_LIMIT_CYCLES = 3200000
) (
    input  logic           clk_sys,
    input  logic           rst,
    input  logic [31:0]    cont1_key,
    input  logic           downloading,
    input  audio_t         core_audio_l,
    input  audio_t         core_audio_r,
    core_settings_if.users settings,
    output logic           fast_forward,
    output audio_t         audio_l,
    output audio_t         audio_r
);

    localparam int CNT_W = $clog2(TAP_LIMIT_CYCLES + 1);

    typedef enum logic [1:0] {
        ff_off,
        ff_held,
        ff_latched,
        ff_release_press
    } ff_state_e;

    ff_state_e        state_q;
    ff_state_e        state_d;
    logic [CNT_W-1:0] hold_cnt;
    logic             press;
    logic             mute;

    // button is ignored while a slot downloads
    assign press = cont1_key[KEY_FAST_FORWARD] & ~downloading;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ff_off: begin
                if (press) begin
                    state_d = ff_held;
                end
            end
            ff_held: begin
                // short tap latches, long hold was momentary
                if (!press) begin
                    state_d = (hold_cnt < CNT_W'(TAP_LIMIT_CYCLES)) ? ff_latched : ff_off;
                end
            end
            ff_latched: begin
                if (press) begin
                    state_d = ff_release_press;
                end
            end
            ff_release_press: begin
                if (!press) begin
                    state_d = ff_off;
                end
            end
            default: state_d = ff_off;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state_q  <= ff_off;
            hold_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ff_off) begin
                hold_cnt <= '0;
            end else if (state_q == ff_held && hold_cnt != CNT_W'(TAP_LIMIT_CYCLES)) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    assign fast_forward = (state_q != ff_off);

    //////////////////////////////////////////////////
    // audio mute while running fast
    //////////////////////////////////////////////////

    assign mute = fast_forward & ~settings.ff_snd_en;

    always_ff @(posedge clk_sys) begin
        audio_l <= mute ? '0 : core_audio_l;
        audio_r <= mute ? '0 : core_audio_r;
    end

endmodule

// File: hw/pocket_gb_shell.sv
`timescale 1ns/10ps

module pocket_gb_shell import host_pkg::*, video_pkg::*; #(
    parameter int RESET_HOLD_CYCLES = 1048576,
    parameter int TAP_LIMIT_CYCLES  = 3200000,
    parameter int HS_DELAY          = 7
) (
    input  logic                 clk_sys,
    input  logic                 rst,
    // host bridge
    input  bridge_addr_t         bridge_addr,
    input  logic                 bridge_rd,
    input  logic                 bridge_wr,
    input  bridge_data_t         bridge_wr_data,
    output bridge_data_t         bridge_rd_data,
    // data slot downloads
    input  logic                 dataslot_requestwrite,
    input  logic [SLOT_ID_W-1:0] dataslot_requestwrite_id,
    input  logic                 dataslot_allcomplete,
    input  logic                 ioctl_wr,
    input  logic [15:0]          ioctl_dout,
    input  logic [31:0]          cont1_key,
    // lcd from the core
    input  shade_t               lcd_shade,
    input  logic                 lcd_hsync,
    input  logic                 lcd_vsync,
    input  logic                 lcd_hblank,
    input  logic                 lcd_vblank,
    input  audio_t               core_audio_l,
    input  audio_t               core_audio_r,
    // to the scaler
    output rgb_t                 video_rgb,
    output logic                 video_de,
    output logic                 video_hs,
    output logic                 video_vs,
    output audio_t               audio_l,
    output audio_t               audio_r,
    output logic                 core_reset
);

    logic downloading;
    logic palette_wr;

    core_settings_if settings ();
    pixel_if         pix ();

    host_regs #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) u_host_regs (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .settings       (settings.regs)
    );

    download_tracker u_download_tracker (
        .clk_sys                  (clk_sys),
        .rst                      (rst),
        .dataslot_requestwrite    (dataslot_requestwrite),
        .dataslot_requestwrite_id (dataslot_requestwrite_id),
        .dataslot_allcomplete     (dataslot_allcomplete),
        .ioctl_wr                 (ioctl_wr),
        .settings                 (settings.users),
        .downloading              (downloading),
        .palette_wr               (palette_wr),
        .core_reset               (core_reset)
    );

    palette_mapper u_palette_mapper (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .palette_wr (palette_wr),
        .ioctl_dout (ioctl_dout),
        .lcd_shade  (lcd_shade),
        .lcd_hsync  (lcd_hsync),
        .lcd_vsync  (lcd_vsync),
        .lcd_hblank (lcd_hblank),
        .lcd_vblank (lcd_vblank),
        .settings   (settings.users),
        .pix        (pix.source)
    );

    video_conditioner #(
        .HS_DELAY(HS_DELAY)
    ) u_video_conditioner (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .pix       (pix.sink),
        .settings  (settings.users),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_hs  (video_hs),
        .video_vs  (video_vs)
    );

    turbo_control #(
        .TAP_LIMIT_CYCLES(TAP_LIMIT_CYCLES)
    ) u_turbo_control (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .cont1_key    (cont1_key),
        .downloading  (downloading),
        .core_audio_l (core_audio_l),
        .core_audio_r (core_audio_r),
        .settings     (settings.users),
        .fast_forward (),
        .audio_l      (audio_l),
        .audio_r      (audio_r)
    );

endmodule

// File: test/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_sys,
    output logic rst
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst <= 1'b0;
    end

endmodule

// File: test/shell_checker.sv
`timescale 1ns/10ps

module shell_checker (
    input logic        clk_sys,
    input logic        rst,
    input logic        video_hs,
    input logic        video_vs,
    input logic        video_de,
    input logic [23:0] video_rgb,
    input logic        fast_forward,
    input logic        ff_snd_en,
    input logic [15:0] audio_l
);

    // sync outputs are single-cycle pulses
    hs_single_pulse: assert property (@(posedge clk_sys) disable iff (rst)
        video_hs |=> !video_hs) else $error("video_hs high two cycles running");

    vs_single_pulse: assert property (@(posedge clk_sys) disable iff (rst)
        video_vs |=> !video_vs) else $error("video_vs high two cycles running");

    rgb_blank: assert property (@(posedge clk_sys) disable iff (rst)
        !video_de |-> video_rgb == '0) else $error("video_rgb not zero outside de");

    audio_mute: assert property (@(posedge clk_sys) disable iff (rst)
        (fast_forward && !ff_snd_en) |=> audio_l == '0) else $error("audio not muted");

endmodule

bind pocket_gb_shell shell_checker u_shell_checker (
    .clk_sys      (clk_sys),
    .rst          (rst),
    .video_hs     (video_hs),
    .video_vs     (video_vs),
    .video_de     (video_de),
    .video_rgb    (video_rgb),
    .fast_forward (u_turbo_control.fast_forward),
    .ff_snd_en    (settings.ff_snd_en),
    .audio_l      (audio_l)
);

// File: test/tb_pocket_gb_shell.sv
`timescale 1ns/10ps

module tb_pocket_gb_shell import host_pkg::*, video_pkg::*; ();

    localparam int PERIOD   = 100;
    localparam int HS_DEL   = 7;
    localparam int NSTEPS   = 27;
    localparam int OP_WR    = 0;
    localparam int OP_RD    = 1;
    localparam int OP_HOLD  = 2;
    localparam int OP_DL    = 3;
    localparam int OP_PIX   = 4;
    localparam int OP_VIDEO = 5;
    localparam int OP_TAP   = 6;
    localparam int OP_TAPDL = 7;
    localparam int OP_AUDIO = 8;

    typedef struct {
        int          op;
        logic [31:0] addr;
        logic [31:0] data;
        int          len;
        logic [31:0] expv;
    } step_t;

    logic clk_sys, rst;
    bridge_addr_t bridge_addr;
    logic bridge_rd, bridge_wr;
    bridge_data_t bridge_wr_data, bridge_rd_data;
    logic dataslot_requestwrite, dataslot_allcomplete, ioctl_wr;
    logic [15:0] dataslot_requestwrite_id, ioctl_dout;
    logic [31:0] cont1_key;
    shade_t lcd_shade;
    logic lcd_hsync, lcd_vsync, lcd_hblank, lcd_vblank;
    audio_t core_audio_l, core_audio_r, audio_l, audio_r;
    rgb_t video_rgb;
    logic video_de, video_hs, video_vs, core_reset;

    step_t steps [NSTEPS];
    int    n_checks;
    int    n_errors;
    logic [15:0]  lfsr;
    logic [127:0] m_pal;
    logic [1:0]   m_tint;
    logic         m_bw;
    logic         m_ff_snd;

    clock_gen #(.PERIOD_NS(PERIOD), .RESET_CYCLES(8)) u_clock_gen (
        .clk_sys (clk_sys),
        .rst     (rst)
    );

    pocket_gb_shell #(
        .RESET_HOLD_CYCLES(16),
        .TAP_LIMIT_CYCLES(20),
        .HS_DELAY(HS_DEL)
    ) UUT (.*);

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
        n_checks++;
        if (got !== expv) begin
            n_errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, expv, $time);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] x);
        return x[0] ? ((x >> 1) ^ 16'hB400) : (x >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // reference colour for one shade under the current settings
    function automatic logic [23:0] expected_rgb(input logic [1:0] s);
        logic [23:0] c;
        int          lum;
        if (m_tint != 0) begin
            c = m_pal[127 - 24 * s -: 24];
        end else begin
            case (s)
                2'd0: c = 24'hFFFFFF;
                2'd1: c = 24'hAAAAAA;
                2'd2: c = 24'h555555;
                default: c = 24'h000000;
            endcase
        end
        if (m_bw) begin
            lum = c[23:16] / 4 + c[23:16] / 32 + c[15:8] / 2 + c[15:8] / 16
                + c[7:0] / 16 + c[7:0] / 32;
            c = {3{lum[7:0]}};
        end
        return c;
    endfunction

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_sys);
        bridge_wr      <= 1'b1;
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        @(posedge clk_sys);
        bridge_wr <= 1'b0;
        case (addr)
            ADDR_TINT:     m_tint = data[1:0];
            ADDR_BW:       m_bw = data[0];
            ADDR_FF_SOUND: m_ff_snd = data[0];
            default:       ;
        endcase
    endtask

    task automatic bridge_read(input logic [31:0] addr, input logic [31:0] expv);
        @(posedge clk_sys);
        bridge_rd   <= 1'b1;
        bridge_addr <= addr;
        @(posedge clk_sys);
        bridge_rd <= 1'b0;
        @(negedge clk_sys);
        check("bridge_rd_data", bridge_rd_data, expv);
    endtask

    task automatic reset_hold(input int len, input int expv);
        int highs;
        highs = 0;
        bridge_write(ADDR_RESET, 32'd1);
        repeat (len) begin
            @(negedge clk_sys);
            highs += core_reset;
        end
        check("core_reset cycles", highs, expv);
    endtask

    task automatic slot_download(input logic [15:0] id, input int len, input logic expv);
        logic [15:0] word;
        @(posedge clk_sys);
        dataslot_requestwrite    <= 1'b1;
        dataslot_requestwrite_id <= id;
        @(posedge clk_sys);
        dataslot_requestwrite <= 1'b0;
        for (int i = 0; i < len; i++) begin
            @(posedge clk_sys);
            if (id == 16'd3) begin
                word = rand_bits(16);
                ioctl_wr   <= 1'b1;
                ioctl_dout <= word;
                // bytes shift in one at a time, low byte first
                m_pal = {m_pal[119:0], word[7:0]};
                m_pal = {m_pal[119:0], word[15:8]};
            end
            @(negedge clk_sys);
            check("core_reset", core_reset, expv);
        end
        @(posedge clk_sys);
        ioctl_wr             <= 1'b0;
        dataslot_allcomplete <= 1'b1;
        @(posedge clk_sys);
        dataslot_allcomplete <= 1'b0;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check("core_reset", core_reset, 0);
    endtask

    task automatic run_pixels(input int len);
        rgb_t   exp_q[$];
        shade_t s;
        for (int i = 0; i < len + 2; i++) begin
            @(posedge clk_sys);
            if (i < len) begin
                s = shade_t'(rand_bits(2));
                lcd_shade  <= s;
                lcd_hblank <= 1'b0;
                lcd_vblank <= 1'b0;
                exp_q.push_back(expected_rgb(s));
            end else begin
                lcd_hblank <= 1'b1;
                lcd_vblank <= 1'b1;
            end
            @(negedge clk_sys);
            if (i >= 2) begin
                check("video_de", video_de, 1);
                check("video_rgb", video_rgb, exp_q.pop_front());
            end
        end
    endtask

    task automatic video_timing(input int len);
        logic de_hist [0:63];
        logic blank;
        logic de_exp;
        for (int i = 0; i < len; i++) begin
            @(posedge clk_sys);
            blank = !(i >= 3 && i < 7);
            de_hist[i] = !blank;
            lcd_hsync  <= (i < 3);
            lcd_vsync  <= (i < 3);
            lcd_hblank <= blank;
            lcd_vblank <= blank;
            @(negedge clk_sys);
            de_exp = (i >= 2) ? de_hist[i - 2] : 1'b0;
            check("video_vs", video_vs, i == 2);
            check("video_hs", video_hs, i == HS_DEL + 2);
            check("video_de", video_de, de_exp);
            if (!de_exp) begin
                check("video_rgb", video_rgb, 0);
            end
        end
    endtask

    // hold the button, check fast_forward while held, then release
    task automatic press_button(input int len, input logic held_exp);
        repeat (len) begin
            @(posedge clk_sys);
            cont1_key <= 32'(1) << KEY_FAST_FORWARD;
        end
        @(negedge clk_sys);
        check("fast_forward", UUT.u_turbo_control.fast_forward, held_exp);
        @(posedge clk_sys);
        cont1_key <= '0;
        repeat (3) @(posedge clk_sys);
    endtask

    task automatic run_tap(input int len, input logic expv);
        press_button(len, 1'b1);
        @(negedge clk_sys);
        check("fast_forward", UUT.u_turbo_control.fast_forward, expv);
        if (expv) begin
            press_button(3, 1'b1);
            @(negedge clk_sys);
            check("fast_forward", UUT.u_turbo_control.fast_forward, 0);
        end
    endtask

    task automatic tap_while_download(input int len);
        @(posedge clk_sys);
        dataslot_requestwrite    <= 1'b1;
        dataslot_requestwrite_id <= 16'd3;
        @(posedge clk_sys);
        dataslot_requestwrite <= 1'b0;
        press_button(len, 1'b0);
        @(negedge clk_sys);
        check("fast_forward", UUT.u_turbo_control.fast_forward, 0);
        @(posedge clk_sys);
        dataslot_allcomplete <= 1'b1;
        @(posedge clk_sys);
        dataslot_allcomplete <= 1'b0;
    endtask

    task automatic run_audio(input int len, input logic with_ff);
        audio_t ql[$];
        audio_t qr[$];
        audio_t sl;
        audio_t sr;
        logic   mute;
        mute = with_ff && !m_ff_snd;
        if (with_ff) begin
            press_button(5, 1'b1);
        end
        for (int i = 0; i < len + 1; i++) begin
            @(posedge clk_sys);
            if (i < len) begin
                sl = audio_t'(rand_bits(16));
                sr = audio_t'(rand_bits(16));
                core_audio_l <= sl;
                core_audio_r <= sr;
                ql.push_back(mute ? 16'sd0 : sl);
                qr.push_back(mute ? 16'sd0 : sr);
            end
            @(negedge clk_sys);
            if (i >= 1) begin
                check("audio_l", 32'(audio_l), 32'(ql.pop_front()));
                check("audio_r", 32'(audio_r), 32'(qr.pop_front()));
            end
        end
        if (with_ff) begin
            press_button(3, 1'b1);
        end
    endtask

    task automatic set_step(input int idx, input int op, input logic [31:0] addr,
                            input logic [31:0] data, input int len, input logic [31:0] expv);
        steps[idx] = '{op, addr, data, len, expv};
    endtask

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    initial begin
        int total;
        total = 40;
        #1;
        foreach (steps[i]) total += steps[i].len + 40;
        #(total * PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        n_checks = 0;
        n_errors = 0;
        lfsr = 16'd88;
        m_pal = PALETTE_DEFAULT;
        m_tint = 2'd0;
        m_bw = 1'b0;
        m_ff_snd = 1'b0;
        bridge_addr = '0;
        bridge_rd = 1'b0;
        bridge_wr = 1'b0;
        bridge_wr_data = '0;
        dataslot_requestwrite = 1'b0;
        dataslot_requestwrite_id = '0;
        dataslot_allcomplete = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_dout = '0;
        cont1_key = '0;
        lcd_shade = '0;
        lcd_hsync = 1'b0;
        lcd_vsync = 1'b0;
        lcd_hblank = 1'b1;
        lcd_vblank = 1'b1;
        core_audio_l = '0;
        core_audio_r = '0;

        // op, address or slot id, data, length, expected
        set_step(0,  OP_WR,    ADDR_TINT,     2, 0, 0);
        set_step(1,  OP_WR,    ADDR_FF_SOUND, 1, 0, 0);
        set_step(2,  OP_WR,    ADDR_BW,       1, 0, 0);
        set_step(3,  OP_RD,    ADDR_TINT,     0, 0, 2);
        set_step(4,  OP_RD,    ADDR_FF_SOUND, 0, 0, 1);
        set_step(5,  OP_RD,    ADDR_BW,       0, 0, 1);
        set_step(6,  OP_RD,    32'h300,       0, 0, 0);
        set_step(7,  OP_WR,    ADDR_TINT,     0, 0, 0);
        set_step(8,  OP_WR,    ADDR_BW,       0, 0, 0);
        set_step(9,  OP_WR,    ADDR_FF_SOUND, 0, 0, 0);
        set_step(10, OP_HOLD,  ADDR_RESET,    1, 40, 16);
        set_step(11, OP_DL,    32'd1,         0, 10, 1);
        set_step(12, OP_PIX,   0,             0, 16, 0);
        set_step(13, OP_DL,    32'd3,         0, 8, 0);
        set_step(14, OP_WR,    ADDR_TINT,     1, 0, 0);
        set_step(15, OP_PIX,   0,             0, 16, 0);
        set_step(16, OP_VIDEO, 0,             0, 16, 0);
        set_step(17, OP_WR,    ADDR_BW,       1, 0, 0);
        set_step(18, OP_PIX,   0,             0, 16, 0);
        set_step(19, OP_WR,    ADDR_BW,       0, 0, 0);
        set_step(20, OP_TAP,   0,             0, 5, 1);
        set_step(21, OP_TAP,   0,             0, 40, 0);
        set_step(22, OP_TAPDL, 0,             0, 5, 0);
        set_step(23, OP_AUDIO, 0,             0, 12, 0);
        set_step(24, OP_AUDIO, 0,             1, 12, 0);
        set_step(25, OP_WR,    ADDR_FF_SOUND, 1, 0, 0);
        set_step(26, OP_AUDIO, 0,             1, 12, 0);

        // state while reset is applied
        repeat (4) @(negedge clk_sys);
        check("core_reset", core_reset, 1);
        check("video_de", video_de, 0);
        check("video_hs", video_hs, 0);
        check("video_vs", video_vs, 0);
        check("fast_forward", UUT.u_turbo_control.fast_forward, 0);
        check("bridge_rd_data", bridge_rd_data, 0);
        while (rst) @(negedge clk_sys);
        @(negedge clk_sys);
        check("core_reset", core_reset, 0);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WR:    bridge_write(steps[i].addr, steps[i].data);
                OP_RD:    bridge_read(steps[i].addr, steps[i].expv);
                OP_HOLD:  reset_hold(steps[i].len, steps[i].expv);
                OP_DL:    slot_download(steps[i].addr[15:0], steps[i].len, steps[i].expv[0]);
                OP_PIX:   run_pixels(steps[i].len);
                OP_VIDEO: video_timing(steps[i].len);
                OP_TAP:   run_tap(steps[i].len, steps[i].expv[0]);
                OP_TAPDL: tap_while_download(steps[i].len);
                OP_AUDIO: run_audio(steps[i].len, steps[i].data[0]);
                default: begin
                    n_errors++;
                    $display("unknown operation in step %0d", i);
                end
            endcase
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/host_pkg.sv
hw/video_pkg.sv
hw/shell_ifs.sv
hw/host_regs.sv
hw/download_tracker.sv
hw/palette_mapper.sv
hw/video_conditioner.sv
hw/turbo_control.sv
hw/pocket_gb_shell.sv
test/clock_gen.sv
test/shell_checker.sv
test/tb_pocket_gb_shell.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pocket_gb_shell
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
